// File: src/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// register and data path width
`define RV_XLEN 32

// register file geometry
`define RV_REG_ADDR_W 5
`define RV_NUM_REGS 32

// program counter
`define RV_RESET_PC 32'h0000_0000
`define RV_INSN_BYTES 4

// byte lanes per data word
`define RV_STRB_W 4

`endif

// File: src/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;

  // major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    opc_lui      = 7'b0110111,
    opc_auipc    = 7'b0010111,
    opc_jal      = 7'b1101111,
    opc_jalr     = 7'b1100111,
    opc_branch   = 7'b1100011,
    opc_load     = 7'b0000011,
    opc_store    = 7'b0100011,
    opc_op_imm   = 7'b0010011,
    opc_op       = 7'b0110011,
    opc_system   = 7'b1110011,
    opc_misc_mem = 7'b0001111
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  typedef enum logic [2:0] {br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu} br_cond_e;

  typedef enum logic [3:0] {
    mem_none, mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu, mem_sb, mem_sh, mem_sw
  } mem_op_e;

  typedef enum logic [1:0] {wb_alu, wb_load, wb_pc_plus4} wb_sel_e;

  typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_type_e;

  typedef enum logic [1:0] {pc_seq, pc_branch, pc_jal, pc_jalr} pc_sel_e;

endpackage

// File: src/rv_ctrl_if.sv
`timescale 1ns/1ps

interface rv_ctrl_if;
  import rv_pkg::*;

  alu_op_e   alu_op;
  logic      a_sel_pc;
  logic      b_sel_imm;
  imm_type_e imm_type;
  br_cond_e  br_cond;
  mem_op_e   mem_op;
  logic      reg_we;
  wb_sel_e   wb_sel;
  pc_sel_e   pc_sel;
  logic      halt;

  modport ctrl (output alu_op, a_sel_pc, b_sel_imm, imm_type, br_cond, mem_op,
                       reg_we, wb_sel, pc_sel, halt);
  modport dp (input alu_op, a_sel_pc, b_sel_imm, imm_type, br_cond, mem_op,
                    reg_we, wb_sel, pc_sel, halt);

endinterface

// File: src/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
  input  rv_pkg::word_t instr,
  rv_ctrl_if.ctrl       ctrl
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       op_legal;

  // alt selects sub or sra from the same funct3
  function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000: op = alt ? alu_sub : alu_add;
      3'b001: op = alu_sll;
      3'b010: op = alu_slt;
      3'b011: op = alu_sltu;
      3'b100: op = alu_xor;
      3'b101: op = alt ? alu_sra : alu_srl;
      3'b110: op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // only funct7 = 0, or 0100000 for sub and sra; M-extension encodings fall out here
  assign op_legal = (funct7 == 7'b0000000) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  always_comb begin
    // defaults give a no-op that just steps the pc
    ctrl.alu_op    = alu_add;
    ctrl.a_sel_pc  = 1'b0;
    ctrl.b_sel_imm = 1'b0;
    ctrl.imm_type  = imm_i;
    ctrl.br_cond   = br_none;
    ctrl.mem_op    = mem_none;
    ctrl.reg_we    = 1'b0;
    ctrl.wb_sel    = wb_alu;
    ctrl.pc_sel    = pc_seq;
    ctrl.halt      = 1'b0;
    case (opcode)
      opc_lui: begin
        ctrl.alu_op    = alu_pass_b;
        ctrl.b_sel_imm = 1'b1;
        ctrl.imm_type  = imm_u;
        ctrl.reg_we    = 1'b1;
      end
      opc_auipc: begin
        ctrl.a_sel_pc  = 1'b1;
        ctrl.b_sel_imm = 1'b1;
        ctrl.imm_type  = imm_u;
        ctrl.reg_we    = 1'b1;
      end
      opc_jal: begin
        ctrl.imm_type = imm_j;
        ctrl.reg_we   = 1'b1;
        ctrl.wb_sel   = wb_pc_plus4;
        ctrl.pc_sel   = pc_jal;
      end
      opc_jalr: begin
        // target comes out of the alu as rs1 + imm
        ctrl.b_sel_imm = 1'b1;
        ctrl.reg_we    = 1'b1;
        ctrl.wb_sel    = wb_pc_plus4;
        ctrl.pc_sel    = pc_jalr;
      end
      opc_branch: begin
        ctrl.imm_type = imm_b;
        case (funct3)
          3'b000: ctrl.br_cond = br_eq;
          3'b001: ctrl.br_cond = br_ne;
          3'b100: ctrl.br_cond = br_lt;
          3'b101: ctrl.br_cond = br_ge;
          3'b110: ctrl.br_cond = br_ltu;
          3'b111: ctrl.br_cond = br_geu;
          default: ctrl.br_cond = br_none;
        endcase
        ctrl.pc_sel = (ctrl.br_cond == br_none) ? pc_seq : pc_branch;
      end
      opc_load: begin
        ctrl.b_sel_imm = 1'b1;
        ctrl.wb_sel    = wb_load;
        case (funct3)
          3'b000: ctrl.mem_op = mem_lb;
          3'b001: ctrl.mem_op = mem_lh;
          3'b010: ctrl.mem_op = mem_lw;
          3'b100: ctrl.mem_op = mem_lbu;
          3'b101: ctrl.mem_op = mem_lhu;
          default: ctrl.mem_op = mem_none;
        endcase
        ctrl.reg_we = (ctrl.mem_op != mem_none);
      end
      opc_store: begin
        ctrl.b_sel_imm = 1'b1;
        ctrl.imm_type  = imm_s;
        case (funct3)
          3'b000: ctrl.mem_op = mem_sb;
          3'b001: ctrl.mem_op = mem_sh;
          3'b010: ctrl.mem_op = mem_sw;
          default: ctrl.mem_op = mem_none;
        endcase
      end
      opc_op_imm: begin
        ctrl.b_sel_imm = 1'b1;
        ctrl.alu_op    = alu_decode(funct3, funct3 == 3'b101 && funct7[5]);
        ctrl.reg_we    = 1'b1;
      end
      opc_op: begin
        ctrl.alu_op = alu_decode(funct3, funct7[5]);
        ctrl.reg_we = op_legal;
      end
      opc_system: begin
        // ecall only, everything else retires as a no-op
        ctrl.halt = (instr[31:7] == '0);
      end
      default: begin
      end
    endcase
  end

endmodule

// File: src/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_regfile (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`RV_REG_ADDR_W-1:0] rs1_addr,
  input  logic [`RV_REG_ADDR_W-1:0] rs2_addr,
  input  logic [`RV_REG_ADDR_W-1:0] rd_addr,
  input  rv_pkg::word_t             rd_data,
  input  logic                      we,
  output rv_pkg::word_t             rs1_data,
  output rv_pkg::word_t             rs2_data
);
  import rv_pkg::*;

  word_t regs [`RV_NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // x0 reads as zero whatever the array holds
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: src/rv_imm_gen.sv
`timescale 1ns/1ps

module rv_imm_gen (
  input  rv_pkg::word_t instr,
  rv_ctrl_if.dp         ctrl,
  output rv_pkg::word_t imm
);
  import rv_pkg::*;

  logic sign;

  assign sign = instr[31];

  always_comb begin
    case (ctrl.imm_type)
      imm_s: imm = {{21{sign}}, instr[30:25], instr[11:7]};
      // branch offsets are in halfwords, bit 0 is always zero
      imm_b: imm = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      imm_u: imm = {instr[31:12], 12'b0};
      imm_j: imm = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default: imm = {{21{sign}}, instr[30:20]};
    endcase
  end

endmodule

// File: src/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::word_t a,
  input  rv_pkg::word_t b,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  rv_ctrl_if.dp         ctrl,
  output rv_pkg::word_t result,
  output logic          br_taken
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       rs_eq;
  logic       rs_lt;
  logic       rs_ltu;

  assign shamt = b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_sll:  result = a << shamt;
      alu_slt:  result = word_t'($signed(a) < $signed(b));
      alu_sltu: result = word_t'(a < b);
      alu_xor:  result = a ^ b;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = word_t'($signed(a) >>> shamt);
      alu_or:   result = a | b;
      alu_and:  result = a & b;
      default:  result = b;
    endcase
  end

  // branch compare works on the register values, not the alu operands
  assign rs_eq  = (rs1_data == rs2_data);
  assign rs_lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign rs_ltu = (rs1_data < rs2_data);

  always_comb begin
    case (ctrl.br_cond)
      br_eq:   br_taken = rs_eq;
      br_ne:   br_taken = !rs_eq;
      br_lt:   br_taken = rs_lt;
      br_ge:   br_taken = !rs_lt;
      br_ltu:  br_taken = rs_ltu;
      br_geu:  br_taken = !rs_ltu;
      default: br_taken = 1'b0;
    endcase
  end

endmodule

// File: src/rv_lsu.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_lsu (
  input  rv_pkg::word_t          addr,
  input  rv_pkg::word_t          store_src,
  rv_ctrl_if.dp                  ctrl,
  output rv_pkg::word_t          dmem_addr,
  output rv_pkg::word_t          dmem_wdata,
  output logic [`RV_STRB_W-1:0]  dmem_we,
  input  rv_pkg::word_t          dmem_rdata,
  output rv_pkg::word_t          load_data
);
  import rv_pkg::*;

  logic [1:0] offset;
  logic [4:0] lane_shift;
  word_t      load_lane;

  assign offset     = addr[1:0];
  assign lane_shift = {offset, 3'b000};

  // memory only sees word addresses
  assign dmem_addr = {addr[`RV_XLEN-1:2], 2'b00};

  always_comb begin
    case (ctrl.mem_op)
      mem_sb: begin
        dmem_wdata = word_t'(store_src[7:0]) << lane_shift;
        dmem_we    = `RV_STRB_W'(4'b0001) << offset;
      end
      mem_sh: begin
        // halfword offset is 0 or 2, bit 0 ignored
        dmem_wdata = word_t'(store_src[15:0]) << {offset[1], 4'b0000};
        dmem_we    = offset[1] ? `RV_STRB_W'(4'b1100) : `RV_STRB_W'(4'b0011);
      end
      mem_sw: begin
        dmem_wdata = store_src;
        dmem_we    = '1;
      end
      default: begin
        dmem_wdata = '0;
        dmem_we    = '0;
      end
    endcase
  end

  // selected lane moved down to bit 0
  assign load_lane = dmem_rdata >> lane_shift;

  always_comb begin
    case (ctrl.mem_op)
      mem_lb:  load_data = {{24{load_lane[7]}}, load_lane[7:0]};
      mem_lbu: load_data = {24'b0, load_lane[7:0]};
      mem_lh:  load_data = {{16{load_lane[15]}}, load_lane[15:0]};
      mem_lhu: load_data = {16'b0, load_lane[15:0]};
      default: load_data = dmem_rdata;
    endcase
  end

endmodule

// File: src/rv_pc_unit.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_pc_unit (
  input  logic          clk,
  input  logic          rst,
  input  logic          halt,
  input  rv_pkg::word_t imm,
  input  rv_pkg::word_t jalr_target,
  input  logic          br_taken,
  rv_ctrl_if.dp         ctrl,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t pc_plus4
);
  import rv_pkg::*;

  word_t pc_next;

  assign pc_plus4 = pc + `RV_INSN_BYTES;

  always_comb begin
    if (halt) begin
      // hold on ecall so halt stays up
      pc_next = pc;
    end else begin
      case (ctrl.pc_sel)
        pc_branch: pc_next = br_taken ? pc + imm : pc_plus4;
        pc_jal:    pc_next = pc + imm;
        pc_jalr:   pc_next = {jalr_target[`RV_XLEN-1:1], 1'b0};
        default:   pc_next = pc_plus4;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

// File: src/rv_core.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core (
  input  logic                  clk,
  input  logic                  rst,
  output rv_pkg::word_t         imem_addr,
  input  rv_pkg::word_t         imem_rdata,
  output rv_pkg::word_t         dmem_addr,
  input  rv_pkg::word_t         dmem_rdata,
  output rv_pkg::word_t         dmem_wdata,
  output logic [`RV_STRB_W-1:0] dmem_we,
  output logic                  halt
);
  import rv_pkg::*;

  word_t rs1_data;
  word_t rs2_data;
  word_t rd_data;
  word_t imm;
  word_t alu_a;
  word_t alu_b;
  word_t alu_result;
  word_t load_data;
  word_t pc;
  word_t pc_plus4;
  logic  br_taken;
  logic [`RV_STRB_W-1:0] lsu_we;

  rv_ctrl_if ctrl_bus ();

  rv_decoder u_decoder (.instr(imem_rdata), .ctrl(ctrl_bus));

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (imem_rdata[19:15]),
    .rs2_addr (imem_rdata[24:20]),
    .rd_addr  (imem_rdata[11:7]),
    .rd_data  (rd_data),
    .we       (ctrl_bus.reg_we),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_imm_gen u_imm_gen (.instr(imem_rdata), .ctrl(ctrl_bus), .imm(imm));

  // operand a takes pc for auipc and operand b takes imm for the I/S/U forms
  assign alu_a = ctrl_bus.a_sel_pc ? pc : rs1_data;
  assign alu_b = ctrl_bus.b_sel_imm ? imm : rs2_data;

  rv_alu u_alu (
    .a        (alu_a),
    .b        (alu_b),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .ctrl     (ctrl_bus),
    .result   (alu_result),
    .br_taken (br_taken)
  );

  rv_lsu u_lsu (
    .addr       (alu_result),
    .store_src  (rs2_data),
    .ctrl       (ctrl_bus),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (lsu_we),
    .dmem_rdata (dmem_rdata),
    .load_data  (load_data)
  );

  rv_pc_unit u_pc_unit (
    .clk         (clk),
    .rst         (rst),
    .halt        (ctrl_bus.halt),
    .imm         (imm),
    .jalr_target (alu_result),
    .br_taken    (br_taken),
    .ctrl        (ctrl_bus),
    .pc          (pc),
    .pc_plus4    (pc_plus4)
  );

  always_comb begin
    case (ctrl_bus.wb_sel)
      wb_load:     rd_data = load_data;
      wb_pc_plus4: rd_data = pc_plus4;
      default:     rd_data = alu_result;
    endcase
  end

  assign imem_addr = pc;
  // no store or halt reaches the pins while reset is held
  assign dmem_we   = rst ? '0 : lsu_we;
  assign halt      = ctrl_bus.halt && !rst;

endmodule

// File: verif/rv_core_props.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core_props (
  input logic                  clk,
  input logic                  rst,
  input rv_pkg::word_t         imem_addr,
  input logic [`RV_STRB_W-1:0] dmem_we,
  input logic                  halt
);
  import rv_pkg::*;

  // fetch address is always a whole instruction
  a_imem_aligned: assert property (@(posedge clk) disable iff (rst) imem_addr[1:0] == 2'b00)
    else $error("imem_addr is not word aligned");

  a_no_store_in_reset: assert property (@(posedge clk) rst |-> dmem_we == '0)
    else $error("dmem_we set during reset");

  // ecall holds the pc
  a_halt_holds_pc: assert property (@(posedge clk) disable iff (rst) halt |=> $stable(imem_addr))
    else $error("imem_addr moved after halt");

  a_no_store_in_halt: assert property (@(posedge clk) disable iff (rst) halt |-> dmem_we == '0)
    else $error("dmem_we set while halted");

endmodule

bind rv_core rv_core_props props (.*);

// File: verif/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core_tb;
  import rv_pkg::*;

  localparam int MEM_WORDS    = 256;
  localparam int DATA_WORDS   = 512;
  localparam int HALT_TIMEOUT = 2000;
  localparam int CLK_HALF     = 2;
  localparam word_t RESET_STORE = 32'h0000_2023;
  localparam word_t RESET_ECALL = 32'h0000_0073;

  logic                  clk;
  logic                  rst;
  word_t                 imem_addr;
  word_t                 imem_rdata;
  word_t                 dmem_addr;
  word_t                 dmem_rdata;
  word_t                 dmem_wdata;
  logic [`RV_STRB_W-1:0] dmem_we;
  logic                  halt;

  word_t imem [MEM_WORDS];
  word_t dmem [MEM_WORDS];
  word_t tdata [DATA_WORDS];
  word_t reset_insn;
  int    prog_len;
  int    store_base;
  int    n_stores;
  int    store_idx;
  word_t halt_pc;
  int    value_errors;
  int    other_errors;

  rv_core dut (.*);

  always #CLK_HALF clk = ~clk;

  // reset fetches a store and then an ecall that must not reach the pins
  assign imem_rdata = rst ? reset_insn : imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    for (int i = 0; i < `RV_STRB_W; i++) begin
      if (dmem_we[i]) begin
        dmem[dmem_addr[9:2]][8*i +: 8] <= dmem_wdata[8*i +: 8];
      end
    end
  end

  function automatic word_t lane_mask(input logic [`RV_STRB_W-1:0] strb);
    word_t m;
    m = '0;
    for (int i = 0; i < `RV_STRB_W; i++) begin
      if (strb[i]) m[8*i +: 8] = 8'hff;
    end
    return m;
  endfunction

  task automatic check_value(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("Fail %0t %s expected=%h actual=%h", $time, name, exp, act);
      value_errors++;
    end
  endtask

  // nothing may be written or halted while reset is held
  always @(negedge clk) begin
    if (rst) begin
      check_value("dmem_we", '0, word_t'(dmem_we));
      check_value("halt", '0, word_t'(halt));
    end
  end

  // each store is compared against the next listed triple
  always @(negedge clk) begin : store_check
    int base;
    if (!rst && dmem_we != '0) begin
      if (store_idx >= n_stores) begin
        $display("Error at %0t: extra store to %h beyond the %0d listed stores",
                 $time, dmem_addr, n_stores);
        other_errors++;
      end else begin
        base = store_base + 3 * store_idx;
        check_value("dmem_addr", tdata[base], dmem_addr);
        check_value("dmem_wdata", tdata[base + 1], dmem_wdata & lane_mask(dmem_we));
        check_value("dmem_we", tdata[base + 2], word_t'(dmem_we));
      end
      store_idx++;
    end
  end

  task automatic finish_run();
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  initial begin : main
    int cycles;
    clk = 1'b0;
    rst = 1'b1;
    reset_insn = RESET_STORE;
    value_errors = 0;
    other_errors = 0;
    store_idx = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      dmem[i] = '0;
    end
    $readmemh("verif/rv_core_testdata.hex", tdata);
    prog_len = tdata[0];
    if ($isunknown(tdata[0]) || prog_len > MEM_WORDS) begin
      $display("Error: test data file missing or program too large");
      other_errors++;
      prog_len = 0;
    end
    for (int i = 0; i < prog_len; i++) begin
      imem[i] = tdata[1 + i];
    end
    n_stores   = tdata[1 + prog_len];
    store_base = 2 + prog_len;
    halt_pc    = tdata[store_base + 3 * n_stores];

    repeat (4) @(posedge clk);
    reset_insn <= RESET_ECALL;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("imem_addr", `RV_RESET_PC, imem_addr);

    cycles = 0;
    while (!halt && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      $display("Error: halt did not rise within %0d cycles", HALT_TIMEOUT);
      other_errors++;
    end else begin
      check_value("imem_addr", halt_pc, imem_addr);
      // the core must stay parked on the ecall
      repeat (10) begin
        @(negedge clk);
        check_value("halt", 32'd1, word_t'(halt));
        check_value("dmem_we", '0, word_t'(dmem_we));
      end
      check_value("store count", n_stores, store_idx);
    end
    finish_run();
  end

endmodule

// File: rv_core.f
+incdir+src
src/rv_pkg.sv
src/rv_ctrl_if.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_imm_gen.sv
src/rv_alu.sv
src/rv_lsu.sv
src/rv_pc_unit.sv
src/rv_core.sv
verif/rv_core_props.sv
verif/rv_core_tb.sv

// File: verif/rv_core_testdata.hex
// program word count, then the instruction words from address 0
// store count, then triples: word-aligned byte address, lane-masked data, strobe; last the halt pc
00000053
// alu register-register and register-immediate, lui, auipc
FFB00093 00300113 002081B3 00302023 402081B3 00302223 002091B3 00302423
0020A1B3 00302623 0020B1B3 00302823 0020C1B3 00302A23 0020D1B3 00302C23
4020D1B3 00302E23 0020E1B3 02302023 0020F1B3 02302223 06408193 02302423
FFC0A193 02302623 0050B193 02302823 0F00C193 02302A23 55016193 02302C23
7F00F193 02302E23 00409193 04302023 0080D193 04302223 4080D193 04302423
// branches from 0xb0, jal and jalr from 0xe0
ABCDE1B7 04302623 12345197 04302823 00208463 04202A23 00209463 3E002823
0020C463 3E002823 0020D463 04202C23 0020E463 04202E23 0020F463 3E002823
008002EF 3E002823 06502023 01128367 3E002823 06602223 876543B7 32138393
// sub-word stores and loads, ecall at 0x148
08700023 081000A3 08700123 081001A3 08701223 08101323 08100183 06302423
08304183 06302623 08601183 06302823 08605183 06302A23 08201183 06302C23
08002183 06302E23 00000073
00000026
00000000 FFFFFFFE 0000000F 00000004 FFFFFFF8 0000000F
00000008 FFFFFFD8 0000000F 0000000C 00000001 0000000F
00000010 00000000 0000000F 00000014 FFFFFFF8 0000000F
00000018 1FFFFFFF 0000000F 0000001C FFFFFFFF 0000000F
00000020 FFFFFFFB 0000000F 00000024 00000003 0000000F
00000028 0000005F 0000000F 0000002C 00000001 0000000F
00000030 00000000 0000000F 00000034 FFFFFF0B 0000000F
00000038 00000553 0000000F 0000003C 000007F0 0000000F
00000040 FFFFFFB0 0000000F 00000044 00FFFFFF 0000000F
00000048 FFFFFFFF 0000000F 0000004C ABCDE000 0000000F
00000050 123450A8 0000000F 00000054 00000003 0000000F
00000058 00000003 0000000F 0000005C 00000003 0000000F
00000060 000000E4 0000000F 00000064 000000F0 0000000F
00000080 00000021 00000001 00000080 0000FB00 00000002
00000080 00210000 00000004 00000080 FB000000 00000008
00000084 00004321 00000003 00000084 FFFB0000 0000000C
00000068 FFFFFFFB 0000000F 0000006C 000000FB 0000000F
00000070 FFFFFFFB 0000000F 00000074 0000FFFB 0000000F
00000078 FFFFFB21 0000000F 0000007C FB21FB21 0000000F
00000148
